/* common/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     pc_t;
    typedef logic [31:0]     insn_t;
    typedef logic [4:0]      reg_addr_t;

    localparam pc_t RESET_PC = 32'h0000_0000;
    localparam pc_t PC_STEP  = 32'd4;

    // addi x0, x0, 0 is what an empty decode slot holds.
    localparam insn_t NOP_INSN = 32'h0000_0013;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_SW   = 3'b010;

    localparam logic [6:0] F7_ALT = 7'b0100000; // selects sub and sra.

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B // returns operand b, used by lui.
    } alu_op_e;

endpackage

/* common/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
    import rv_pkg::*;

    logic      rd_wr_en;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;       // already sign extended.
    logic      use_imm;
    alu_op_e   alu_op;
    logic      is_store;

    modport producer (
        output rd_wr_en, rd_addr, rs1_addr, rs2_addr, rs1_data, rs2_data,
        output imm, use_imm, alu_op, is_store
    );

    modport consumer (
        input rd_wr_en, rd_addr, rs1_addr, rs2_addr, rs1_data, rs2_data,
        input imm, use_imm, alu_op, is_store
    );

endinterface

/* common/exec_if.sv */
`timescale 1ns/1ps

interface exec_if;
    import rv_pkg::*;

    logic      rd_wr_en;
    reg_addr_t rd_addr;
    word_t     result;     // holds the store address for a store.
    logic      is_store;
    word_t     store_data;

    modport producer (
        output rd_wr_en, rd_addr, result, is_store, store_data
    );

    modport consumer (
        input rd_wr_en, rd_addr, result, is_store, store_data
    );

endinterface

/* rtl/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t i_rs1_addr,
    input  rv_pkg::reg_addr_t i_rs2_addr,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data,
    input  logic              i_wr_en,
    input  rv_pkg::reg_addr_t i_wr_addr,
    input  rv_pkg::word_t     i_wr_data
);
    import rv_pkg::*;

    word_t regs [NUM_REGS];

    // a write landing this cycle is seen by the reader, which closes distance three.
    function automatic word_t read_reg(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wr_en && (i_wr_addr == addr)) begin
            return i_wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n && i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data; // x0 is never written.
        end
    end

    always_comb begin
        o_rs1_data = read_reg(i_rs1_addr);
        o_rs2_data = read_reg(i_rs2_addr);
    end

endmodule

/* frontend/fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_stall,
    input  rv_pkg::insn_t     i_insn,
    output rv_pkg::pc_t       o_pc,
    output rv_pkg::reg_addr_t o_rs1_addr,
    output rv_pkg::reg_addr_t o_rs2_addr,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    decode_if.producer        dec
);
    import rv_pkg::*;

    pc_t        pc_q;
    insn_t      insn_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    alu_op_e    alu_sel;
    logic       alu_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q   <= RESET_PC;
            insn_q <= NOP_INSN;
        end else if (!i_stall) begin
            pc_q   <= pc_q + PC_STEP;
            insn_q <= i_insn; // sampled on the same edge that moves the pc.
        end
    end

    assign o_pc   = pc_q;
    assign opcode = insn_q[6:0];
    assign funct3 = insn_q[14:12];
    assign funct7 = insn_q[31:25];

    assign imm_i = {{20{insn_q[31]}}, insn_q[31:20]};
    assign imm_s = {{20{insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
    assign imm_u = {insn_q[31:12], 12'b0};

    assign o_rs1_addr    = insn_q[19:15];
    assign o_rs2_addr    = insn_q[24:20];
    assign dec.rs1_addr  = insn_q[19:15];
    assign dec.rs2_addr  = insn_q[24:20];
    assign dec.rd_addr   = insn_q[11:7];
    assign dec.rs1_data  = i_rs1_data;
    assign dec.rs2_data  = i_rs2_data;

    // funct7 only matters for sub, sra and the shift immediates.
    always_comb begin
        case (funct3)
            F3_ADD:  alu_sel = (opcode == OPC_OP && funct7 == F7_ALT) ? SUB : ADD;
            F3_SLL:  alu_sel = SLL;
            F3_SLT:  alu_sel = SLT;
            F3_SLTU: alu_sel = SLTU;
            F3_XOR:  alu_sel = XOR;
            F3_SR:   alu_sel = (funct7 == F7_ALT) ? SRA : SRL;
            F3_OR:   alu_sel = OR;
            default: alu_sel = AND;
        endcase

        if (opcode == OPC_OP) begin
            alu_ok = (funct7 == 7'b0) ||
                     (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
        end else if (funct3 == F3_SLL) begin
            alu_ok = (funct7 == 7'b0);
        end else if (funct3 == F3_SR) begin
            alu_ok = (funct7 == 7'b0) || (funct7 == F7_ALT);
        end else begin
            alu_ok = 1'b1;
        end
    end

    always_comb begin
        dec.rd_wr_en = 1'b0;
        dec.is_store = 1'b0;
        dec.use_imm  = 1'b0;
        dec.alu_op   = ADD;
        dec.imm      = imm_i;
        case (opcode)
            OPC_LUI: begin
                dec.rd_wr_en = 1'b1;
                dec.use_imm  = 1'b1;
                dec.alu_op   = PASS_B;
                dec.imm      = imm_u;
            end
            OPC_OP_IMM: begin
                dec.rd_wr_en = alu_ok;
                dec.use_imm  = 1'b1;
                dec.alu_op   = alu_sel;
            end
            OPC_OP: begin
                dec.rd_wr_en = alu_ok;
                dec.alu_op   = alu_sel;
            end
            OPC_STORE: begin
                dec.is_store = (funct3 == F3_SW); // sb and sh fall through as no-ops.
                dec.use_imm  = 1'b1;
                dec.imm      = imm_s;
            end
            default: ;
        endcase
    end

endmodule

/* backend/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_stall,
    decode_if.consumer        dec,
    exec_if.producer          ex,
    input  logic              i_m_wr_en,
    input  rv_pkg::reg_addr_t i_m_wr_addr,
    input  rv_pkg::word_t     i_m_wr_data,
    input  logic              i_w_wr_en,
    input  rv_pkg::reg_addr_t i_w_wr_addr,
    input  rv_pkg::word_t     i_w_wr_data
);
    import rv_pkg::*;

    logic      x_rd_wr_en;
    logic      x_is_store;
    reg_addr_t x_rd_addr;
    reg_addr_t x_rs1_addr;
    reg_addr_t x_rs2_addr;
    word_t     x_rs1_data;
    word_t     x_rs2_data;
    word_t     x_imm;
    logic      x_use_imm;
    alu_op_e   x_alu_op;

    word_t     op_a;
    word_t     rs2_fwd;
    word_t     op_b;
    word_t     alu_out;

    // the younger result in memory wins over the older one in writeback.
    function automatic word_t forward(input reg_addr_t addr, input word_t reg_val);
        if (addr != '0 && i_m_wr_en && i_m_wr_addr == addr) begin
            return i_m_wr_data;
        end else if (addr != '0 && i_w_wr_en && i_w_wr_addr == addr) begin
            return i_w_wr_data;
        end
        return reg_val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_rd_wr_en <= 1'b0;
            x_is_store <= 1'b0;
        end else if (!i_stall) begin
            x_rd_wr_en <= dec.rd_wr_en;
            x_is_store <= dec.is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            x_rd_addr  <= dec.rd_addr;
            x_rs1_addr <= dec.rs1_addr;
            x_rs2_addr <= dec.rs2_addr;
            x_rs1_data <= dec.rs1_data;
            x_rs2_data <= dec.rs2_data;
            x_imm      <= dec.imm;
            x_use_imm  <= dec.use_imm;
            x_alu_op   <= dec.alu_op;
        end
    end

    always_comb begin
        op_a    = forward(x_rs1_addr, x_rs1_data);
        rs2_fwd = forward(x_rs2_addr, x_rs2_data);
        op_b    = x_use_imm ? x_imm : rs2_fwd;
    end

    always_comb begin
        case (x_alu_op)
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;
            SLL:     alu_out = op_a << op_b[4:0];
            SLT:     alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            XOR:     alu_out = op_a ^ op_b;
            SRL:     alu_out = op_a >> op_b[4:0];
            SRA:     alu_out = $signed(op_a) >>> op_b[4:0];
            OR:      alu_out = op_a | op_b;
            AND:     alu_out = op_a & op_b;
            default: alu_out = op_b;
        endcase
    end

    assign ex.rd_wr_en   = x_rd_wr_en;
    assign ex.rd_addr    = x_rd_addr;
    assign ex.result     = alu_out;  // a store decodes to add, so this is rs1 plus imm.
    assign ex.is_store   = x_is_store;
    assign ex.store_data = rs2_fwd;

endmodule

/* backend/retire_stage.sv */
`timescale 1ns/1ps

module retire_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_stall,
    exec_if.consumer          ex,
    output logic              o_m_wr_en,
    output rv_pkg::reg_addr_t o_m_wr_addr,
    output rv_pkg::word_t     o_m_wr_data,
    output logic              o_w_wr_en,
    output rv_pkg::reg_addr_t o_w_wr_addr,
    output rv_pkg::word_t     o_w_wr_data,
    output logic              o_dmem_wr_en,
    output rv_pkg::word_t     o_dmem_addr,
    output rv_pkg::word_t     o_dmem_wr_data
);
    import rv_pkg::*;

    logic      m_rd_wr_en;
    logic      m_is_store;
    reg_addr_t m_rd_addr;
    word_t     m_result;
    word_t     m_store_data;

    logic      w_rd_wr_en;
    reg_addr_t w_rd_addr;
    word_t     w_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_rd_wr_en <= 1'b0;
            m_is_store <= 1'b0;
            w_rd_wr_en <= 1'b0;
        end else if (!i_stall) begin
            m_rd_wr_en <= ex.rd_wr_en;
            m_is_store <= ex.is_store;
            w_rd_wr_en <= m_rd_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            m_rd_addr    <= ex.rd_addr;
            m_result     <= ex.result;
            m_store_data <= ex.store_data;
            w_rd_addr    <= m_rd_addr;
            w_result     <= m_result;
        end
    end

    // held stages would repeat the store, so the enable drops during a halt.
    assign o_dmem_wr_en   = m_is_store && !i_stall;
    assign o_dmem_addr    = m_result;
    assign o_dmem_wr_data = m_store_data;

    assign o_m_wr_en   = m_rd_wr_en;
    assign o_m_wr_addr = m_rd_addr;
    assign o_m_wr_data = m_result;

    assign o_w_wr_en   = w_rd_wr_en;
    assign o_w_wr_addr = w_rd_addr;
    assign o_w_wr_data = w_result;

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::insn_t i_insn,
    output rv_pkg::pc_t   o_pc,
    input  logic          i_fetch_halt,
    output logic          o_dmem_wr_en,
    output rv_pkg::word_t o_dmem_addr,
    output rv_pkg::word_t o_dmem_wr_data
);
    import rv_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    logic      m_wr_en;
    reg_addr_t m_wr_addr;
    word_t     m_wr_data;
    logic      w_wr_en;
    reg_addr_t w_wr_addr;
    word_t     w_wr_data;

    decode_if dec_bus ();
    exec_if   ex_bus ();

    fetch_decode u_fetch_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_stall    (i_fetch_halt),
        .i_insn     (i_insn),
        .o_pc       (o_pc),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .dec        (dec_bus.producer)
    );

    gpr_file u_gpr_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wr_en    (w_wr_en),
        .i_wr_addr  (w_wr_addr),
        .i_wr_data  (w_wr_data)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_stall     (i_fetch_halt),
        .dec         (dec_bus.consumer),
        .ex          (ex_bus.producer),
        .i_m_wr_en   (m_wr_en),
        .i_m_wr_addr (m_wr_addr),
        .i_m_wr_data (m_wr_data),
        .i_w_wr_en   (w_wr_en),
        .i_w_wr_addr (w_wr_addr),
        .i_w_wr_data (w_wr_data)
    );

    retire_stage u_retire_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_stall        (i_fetch_halt),
        .ex             (ex_bus.consumer),
        .o_m_wr_en      (m_wr_en),
        .o_m_wr_addr    (m_wr_addr),
        .o_m_wr_data    (m_wr_data),
        .o_w_wr_en      (w_wr_en),
        .o_w_wr_addr    (w_wr_addr),
        .o_w_wr_data    (w_wr_data),
        .o_dmem_wr_en   (o_dmem_wr_en),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_wr_data (o_dmem_wr_data)
    );

endmodule

/* bench/rv_core_assertions.sv */
`timescale 1ns/1ps

module rv_core_assertions (
    input logic        clk,
    input logic        rst_n,
    input logic        i_fetch_halt,
    input logic        o_dmem_wr_en,
    input rv_pkg::pc_t o_pc
);
    import rv_pkg::*;

    // a frozen memory stage would otherwise write the same word twice.
    no_store_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
        i_fetch_halt |-> !o_dmem_wr_en)
        else $error("store enable high while the fetch halt is high");

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        o_pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (o_pc == ($past(i_fetch_halt) ? $past(o_pc) : $past(o_pc) + PC_STEP)))
        else $error("pc neither held under halt nor stepped by one word");

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_fetch_halt (i_fetch_halt),
    .o_dmem_wr_en (o_dmem_wr_en),
    .o_pc         (o_pc)
);

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int PROG_MAX   = 128;
    localparam int NUM_BLOCKS = 8;
    localparam int BLOCK_ALU  = 6;
    localparam int DRAIN      = 8;
    localparam int MAX_CYCLES = 4000;

    logic  clk;
    logic  rst_n;
    insn_t i_insn;
    pc_t   o_pc;
    logic  i_fetch_halt;
    logic  o_dmem_wr_en;
    word_t o_dmem_addr;
    word_t o_dmem_wr_data;

    logic [31:0] lfsr;
    insn_t       prog [PROG_MAX];
    int          prog_len;
    word_t       mregs [NUM_REGS];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int          tests_run;

    rv_core DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_insn         (i_insn),
        .o_pc           (o_pc),
        .i_fetch_halt   (i_fetch_halt),
        .o_dmem_wr_en   (o_dmem_wr_en),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_wr_data (o_dmem_wr_data)
    );

    always #2 clk = ~clk;

    // the feedback uses taps 32, 22, 2 and 1 and shifts once for every bit handed out.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? sra : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic insn_t fetch_word(input pc_t pc);
        if (pc[31:9] == '0 && int'(pc[8:2]) < prog_len) begin
            return prog[pc[8:2]];
        end
        return NOP_INSN; // past the end the core sees no-ops.
    endfunction

    task automatic emit(input insn_t insn);
        prog[prog_len[6:0]] = insn;
        prog_len++;
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        test_checks++;
        if (actual !== expected) begin
            test_errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic gen_alu(output reg_addr_t rd);
        logic [31:0] r;
        logic [1:0]  kind;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        word_t       res;
        r    = rand_bits(2);
        kind = r[1:0];
        r    = rand_bits(3);
        rd   = {2'b00, r[2:0]}; // indices stay within x0 to x7 so that dependencies come often.
        r    = rand_bits(3);
        rs1  = {2'b00, r[2:0]};
        r    = rand_bits(3);
        rs2  = {2'b00, r[2:0]};
        r    = rand_bits(3);
        f3   = r[2:0];
        r    = rand_bits(1);
        alt  = r[0];
        r    = rand_bits(12);
        imm  = r[11:0];
        case (kind)
            2'd0: begin
                r   = rand_bits(20);
                res = {r[19:0], 12'h000};
                emit({r[19:0], rd, OPC_LUI});
            end
            2'd1: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    alt = alt && (f3 == 3'b101);
                    imm = {1'b0, alt, 5'b00000, imm[4:0]};
                    res = alu_ref(f3, alt, mregs[rs1], {27'd0, imm[4:0]});
                end else begin
                    res = alu_ref(f3, 1'b0, mregs[rs1], {{20{imm[11]}}, imm});
                end
                emit({imm, rs1, f3, rd, OPC_OP_IMM});
            end
            default: begin
                alt = alt && (f3 == 3'b000 || f3 == 3'b101);
                res = alu_ref(f3, alt, mregs[rs1], mregs[rs2]);
                emit({1'b0, alt, 5'b00000, rs2, rs1, f3, rd, OPC_OP});
            end
        endcase
        if (rd != 5'd0) begin
            mregs[rd] = res;
        end
    endtask

    task automatic gen_store(input reg_addr_t src);
        logic [11:0] off;
        off = 12'(16 + 4 * exp_addr.size()); // every store gets its own word.
        emit({off[11:5], src, 5'd0, F3_SW, off[4:0], OPC_STORE});
        exp_addr.push_back({{20{off[11]}}, off});
        exp_data.push_back(mregs[src]);
    endtask

    task automatic build_program();
        logic [31:0] r;
        reg_addr_t   ra;
        reg_addr_t   rds [$];
        prog_len = 0;
        mregs    = '{default: '0};
        exp_addr.delete();
        exp_data.delete();
        for (int i = 1; i < 8; i++) begin
            r  = rand_bits(12);
            ra = 5'(i);
            emit({r[11:0], 5'd0, F3_ADD, ra, OPC_OP_IMM});
            mregs[ra] = {{20{r[11]}}, r[11:0]};
        end
        emit({7'd0, 5'd2, 5'd1, F3_ADD, 5'd0, OPC_OP}); // add into x0 must leave it zero.
        gen_store(5'd0);
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int k = 0; k < BLOCK_ALU; k++) begin
                gen_alu(ra);
                rds.push_back(ra);
            end
            while (rds.size() > 0) begin
                gen_store(rds.pop_back()); // the newest result is stored first to use forwarding.
            end
        end
    endtask

    task automatic run_program(input string name, input logic use_halt);
        int          cycles;
        int          seen;
        pc_t         prev_pc;
        logic        prev_halt;
        logic [31:0] r;
        test_checks  = 0;
        test_errors  = 0;
        rst_n        = 1'b0;
        i_fetch_halt = 1'b0;
        i_insn       = NOP_INSN;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("o_dmem_wr_en", {31'd0, o_dmem_wr_en}, 32'd0);
        end
        check_value("o_pc", o_pc, RESET_PC);
        rst_n     = 1'b1;
        i_insn    = fetch_word(o_pc);
        prev_pc   = RESET_PC;
        prev_halt = 1'b0;
        seen      = 0;
        cycles    = 0;
        while (int'(o_pc[31:2]) < prog_len + DRAIN && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
            r            = rand_bits(2);
            i_fetch_halt = use_halt && (r[1:0] == 2'b00);
            i_insn       = fetch_word(o_pc);
            #1;
            check_value("o_pc", o_pc, prev_halt ? prev_pc : prev_pc + PC_STEP);
            if (i_fetch_halt && o_dmem_wr_en) begin
                test_errors++;
                $display("ERROR: store enable is high while the fetch halt is high");
            end
            if (o_dmem_wr_en) begin
                if (seen < exp_addr.size()) begin
                    check_value($sformatf("o_dmem_addr[%0d]", seen), o_dmem_addr, exp_addr[seen]);
                    check_value($sformatf("o_dmem_wr_data[%0d]", seen), o_dmem_wr_data,
                                exp_data[seen]);
                end else begin
                    test_errors++;
                    $display("ERROR: extra store to 0x%08h after all %0d expected stores",
                             o_dmem_addr, exp_addr.size());
                end
                seen++;
            end
            prev_pc   = o_pc;
            prev_halt = i_fetch_halt;
        end
        if (cycles >= MAX_CYCLES) begin
            test_errors++;
            $display("ERROR: test %s did not reach the end of the program in %0d cycles",
                     name, MAX_CYCLES);
        end
        check_value("store_count", 32'(seen), 32'(exp_addr.size()));
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_run++;
    endtask

    initial begin
        lfsr         = 32'hccc2038e;
        clk          = 1'b0;
        rst_n        = 1'b0;
        i_fetch_halt = 1'b0;
        i_insn       = NOP_INSN;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        build_program();
        run_program("no_halt", 1'b0);
        run_program("random_halt", 1'b1);
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, total_checks,
                 total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* build.f */
common/rv_pkg.sv
common/decode_if.sv
common/exec_if.sv
rtl/gpr_file.sv
frontend/fetch_decode.sv
backend/execute_stage.sv
backend/retire_stage.sv
rtl/rv_core.sv
bench/rv_core_assertions.sv
bench/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
